// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = sampleBridgeTb
FILELIST = tb.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "Result: no result line"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: src/asyncFifo.sv
/* Dual-clock FIFO with binary and gray pointers per domain,
   asynchronous pointer compare and filtered rok and wok levels */
`timescale 1ns/100ps
module asyncFifo #(
    parameter int Size = 8
) (
    input  logic                            wclk,
    input  logic                            wrstN,
    input  logic                            wtrigger,
    input  logic [fifoPkg::WordWidth-1:0]   wdata,
    output logic                            wok,
    input  logic                            rclk,
    input  logic                            rrstN,
    input  logic                            rtrigger,
    output logic [fifoPkg::WordWidth-1:0]   rdata,
    output logic                            rok
);
    // Pointer top index, low N bits address the memory
    localparam int N = fifoPkg::ptrWidth(Size) - 1;

    logic [fifoPkg::WordWidth-1:0] mem [Size];

    // Read pointers (binary, gray, gray delayed)
    logic [N:0] rbaddr, rgaddr, rgaddrDelayed, rbaddrNext;
    // Write pointers (binary, gray, gray delayed)
    logic [N:0] wbaddr, wgaddr, wgaddrDelayed, wbaddrNext;

    logic [1:0] rokReg;
    logic [1:0] wokRegN;
    logic       rempty, wfull;
    logic       readAvail, writeSpace;
    logic       rokClrN, wokSetN;

    // ====================
    // Read side
    // ====================
    assign rbaddrNext = rbaddr + 1'b1;

    always_ff @(posedge rclk or negedge rrstN) begin
        if (!rrstN) begin
            rbaddr        <= '0;
            rgaddr        <= '0;
            rgaddrDelayed <= '0;
        end else begin
            rgaddrDelayed <= rgaddr;
            if (rtrigger && rok) begin
                rbaddr <= rbaddrNext;
                rgaddr <= (rbaddrNext >> 1) ^ rbaddrNext;
            end
        end
    end

    // Empty clears rok at once, data present sets it two edges later
    assign rokClrN = readAvail && rrstN;

    always_ff @(posedge rclk or negedge rokClrN) begin
        if (!rokClrN) begin
            rokReg <= 2'b00;
        end else begin
            rokReg <= {rokReg[0], 1'b1};
        end
    end

    assign rdata = mem[rbaddr[N-1:0]];
    assign rok   = rokReg[1];

    // ====================
    // Write side
    // ====================
    assign wbaddrNext = wbaddr + 1'b1;

    always_ff @(posedge wclk or negedge wrstN) begin
        if (!wrstN) begin
            wbaddr        <= '0;
            wgaddr        <= '0;
            wgaddrDelayed <= '0;
        end else begin
            wgaddrDelayed <= wgaddr;
            if (wtrigger && wok) begin
                wbaddr <= wbaddrNext;
                wgaddr <= (wbaddrNext >> 1) ^ wbaddrNext;
            end
        end
    end

    always_ff @(posedge wclk) begin
        if (wtrigger && wok) begin
            mem[wbaddr[N-1:0]] <= wdata;
        end
    end

    // Inverted filter so wok is low while full
    assign wokSetN = writeSpace && wrstN;

    always_ff @(posedge wclk or negedge wokSetN) begin
        if (!wokSetN) begin
            wokRegN <= 2'b11;
        end else begin
            wokRegN <= {wokRegN[0], 1'b0};
        end
    end

    assign wok = !wokRegN[1];

    // ====================
    // Pointer compare
    // ====================
    // Full when write leads read by Size, seen as top two gray bits flipped
    assign rempty     = (rgaddr == wgaddrDelayed);
    assign wfull      = (wgaddr == {~rgaddrDelayed[N:N-1], rgaddrDelayed[N-2:0]});
    assign readAvail  = !rempty;
    assign writeSpace = !wfull;

    // Depth has to suit the gray full test
    assert property (@(posedge wclk) (Size >= 4) && ((Size & (Size - 1)) == 0))
        else $error("asyncFifo Size must be a power of two and at least 4");

    // Reader pops only a word that rok reports
    assert property (@(posedge rclk) disable iff (!rrstN) rtrigger |-> rok)
        else $error("asyncFifo pop while rok low");

    // A write let through by wok never lands on a full FIFO
    // True fill level taken from the live binary pointers
    assert property (@(posedge wclk) disable iff (!wrstN)
        (wtrigger && wok) |-> ((N+1)'(wbaddr - rbaddr) < Size))
        else $error("asyncFifo write accepted while full");

endmodule

// File: src/fifoPkg.sv
/* FIFO word width and pointer width function */
package fifoPkg;

    // ====================
    // Storage geometry
    // ====================

    // Bits per stored word
    // Matches the stream word layout
    localparam int WordWidth = 12;

    // Pointer width for a FIFO of the given depth
    // One bit above the address separates full from empty
    function automatic int ptrWidth(input int size);
        return $clog2(size) + 1;
    endfunction

endpackage

// File: src/frameUnpacker.sv
/* Read-side unpacker with word decode, sample and frame strobes
   and marker sequence check */
`timescale 1ns/100ps
module frameUnpacker (
    input  logic                                rclk,
    input  logic                                rrstN,
    input  logic                                readEnable,
    input  logic                                rok,
    input  streamPkg::streamWord                rdata,
    output logic                                rtrigger,
    output logic                                sampleValid,
    output logic [streamPkg::SampleWidth-1:0]   sampleOut,
    output logic                                frameStart,
    output logic [streamPkg::ChannelWidth-1:0]  frameChannel,
    output logic [streamPkg::SeqWidth-1:0]      frameSeq,
    output logic                                seqError
);
    logic                           isMarker;
    logic                           haveSeq;
    logic [streamPkg::SeqWidth-1:0] lastSeq;
    logic [streamPkg::SeqWidth-1:0] expectSeq;

    // Pop whenever a word waits and the outside allows it
    assign rtrigger = readEnable && rok;

    // Kind bit sits in the same place in both views
    assign isMarker = (rdata.mrk.kind == streamPkg::KindMarker);

    // Wraps at 256
    assign expectSeq = lastSeq + 1'b1;

    // ====================
    // Strobes and sequence state
    // ====================
    always_ff @(posedge rclk or negedge rrstN) begin
        if (!rrstN) begin
            sampleValid <= 1'b0;
            frameStart  <= 1'b0;
            seqError    <= 1'b0;
            haveSeq     <= 1'b0;
            lastSeq     <= '0;
        end else begin
            sampleValid <= rtrigger && !isMarker;
            frameStart  <= rtrigger && isMarker;
            // First marker only seeds the check
            seqError    <= rtrigger && isMarker && haveSeq && (rdata.mrk.seq != expectSeq);
            if (rtrigger && isMarker) begin
                haveSeq <= 1'b1;
                lastSeq <= rdata.mrk.seq;
            end
        end
    end

    // ====================
    // Field capture
    // ====================
    always_ff @(posedge rclk) begin
        if (rtrigger) begin
            if (isMarker) begin
                frameChannel <= rdata.mrk.channel;
                frameSeq     <= rdata.mrk.seq;
            end else begin
                sampleOut <= rdata.smp.value;
            end
        end
    end

    // A popped word always holds defined data
    assert property (@(posedge rclk) disable iff (!rrstN) rtrigger |-> !$isunknown(rdata))
        else $error("frameUnpacker popped an undefined word");

endmodule

// File: src/sampleBridge.sv
/* Sample bridge top with per-domain reset synchronizers, framer,
   dual-clock FIFO and unpacker */
`timescale 1ns/100ps
module sampleBridge #(
    parameter int Size     = 8,
    parameter int FrameLen = 4
) (
    input  logic                                rclk,
    input  logic                                wclk,
    input  logic                                asyncReadOK,
    input  logic                                sampleStrobe,
    input  logic [streamPkg::SampleWidth-1:0]   sample,
    input  logic [streamPkg::ChannelWidth-1:0]  channel,
    input  logic                                readEnable,
    output logic [15:0]                         dropCount,
    output logic                                sampleValid,
    output logic [streamPkg::SampleWidth-1:0]   sampleOut,
    output logic                                frameStart,
    output logic [streamPkg::ChannelWidth-1:0]  frameChannel,
    output logic [streamPkg::SeqWidth-1:0]      frameSeq,
    output logic                                seqError
);
    // Domain 0 is wclk, domain 1 is rclk
    logic [1:0]                     domClk;
    logic [1:0]                     domRstN;
    logic                           wrstN, rrstN;
    logic                           wtrigger, wok, rtrigger, rok;
    logic [fifoPkg::WordWidth-1:0]  wdata, rdata;

    assign domClk = {rclk, wclk};

    // ====================
    // Reset synchronizers
    // ====================
    // Assert at once, release after two edges of the local clock
    for (genvar d = 0; d < 2; d++) begin : gRstSync
        logic [1:0] stage;

        always_ff @(posedge domClk[d] or negedge asyncReadOK) begin
            if (!asyncReadOK) begin
                stage <= 2'b00;
            end else begin
                stage <= {stage[0], 1'b1};
            end
        end

        assign domRstN[d] = stage[1];
    end

    assign wrstN = domRstN[0];
    assign rrstN = domRstN[1];

    // Write domain
    sampleFramer #(.FrameLen(FrameLen)) u_sampleFramer (
        .wclk(wclk), .wrstN(wrstN), .sampleStrobe(sampleStrobe), .sample(sample),
        .channel(channel), .wok(wok), .wtrigger(wtrigger), .wdata(wdata),
        .dropCount(dropCount)
    );

    // Crossing
    asyncFifo #(.Size(Size)) u_asyncFifo (
        .wclk(wclk), .wrstN(wrstN), .wtrigger(wtrigger), .wdata(wdata), .wok(wok),
        .rclk(rclk), .rrstN(rrstN), .rtrigger(rtrigger), .rdata(rdata), .rok(rok)
    );

    // Read domain
    frameUnpacker u_frameUnpacker (
        .rclk(rclk), .rrstN(rrstN), .readEnable(readEnable), .rok(rok), .rdata(rdata),
        .rtrigger(rtrigger), .sampleValid(sampleValid), .sampleOut(sampleOut),
        .frameStart(frameStart), .frameChannel(frameChannel), .frameSeq(frameSeq),
        .seqError(seqError)
    );

endmodule

// File: src/sampleFramer.sv
/* Write-side framer with marker insertion, one-sample hold slot,
   FIFO write strobe and drop counter */
`timescale 1ns/100ps
module sampleFramer #(
    parameter int FrameLen = 4
) (
    input  logic                                wclk,
    input  logic                                wrstN,
    input  logic                                sampleStrobe,
    input  logic [streamPkg::SampleWidth-1:0]   sample,
    input  logic [streamPkg::ChannelWidth-1:0]  channel,
    input  logic                                wok,
    output logic                                wtrigger,
    output streamPkg::streamWord                wdata,
    output logic [15:0]                         dropCount
);
    // Position of the next sample inside its frame
    localparam int IdxWidth = (FrameLen > 1) ? $clog2(FrameLen) : 1;
    localparam logic [IdxWidth-1:0] LastIdx = IdxWidth'(FrameLen - 1);

    logic [IdxWidth-1:0]                sampleIdx;
    logic [streamPkg::SeqWidth-1:0]     seqCount;
    logic                               holdValid;
    logic [streamPkg::SampleWidth-1:0]  holdSample;
    logic                               frameFirst;

    // Next strobe opens a new frame
    assign frameFirst = (sampleIdx == '0);

    // ====================
    // Control
    // ====================
    always_ff @(posedge wclk or negedge wrstN) begin
        if (!wrstN) begin
            wtrigger  <= 1'b0;
            holdValid <= 1'b0;
            sampleIdx <= '0;
            seqCount  <= '0;
            dropCount <= '0;
        end else begin
            // Word was due but the FIFO had no room
            if (wtrigger && !wok) begin
                dropCount <= dropCount + 1'b1;
            end
            // Held sample goes out right behind its marker
            wtrigger  <= holdValid || sampleStrobe;
            holdValid <= sampleStrobe && frameFirst;
            if (sampleStrobe) begin
                // Sequence moves on per frame even if the marker is lost
                if (frameFirst) begin
                    seqCount <= seqCount + 1'b1;
                end
                sampleIdx <= (sampleIdx == LastIdx) ? '0 : sampleIdx + 1'b1;
            end
        end
    end

    // ====================
    // Word build
    // ====================
    always_ff @(posedge wclk) begin
        if (holdValid) begin
            wdata.smp.kind  <= streamPkg::KindSample;
            wdata.smp.value <= holdSample;
        end else if (sampleStrobe) begin
            if (frameFirst) begin
                // Marker first, sample parked for one cycle
                wdata.mrk.kind    <= streamPkg::KindMarker;
                wdata.mrk.channel <= channel;
                wdata.mrk.seq     <= seqCount;
                holdSample        <= sample;
            end else begin
                wdata.smp.kind  <= streamPkg::KindSample;
                wdata.smp.value <= sample;
            end
        end
    end

    // Hold slot needs an idle cycle after every strobe
    assert property (@(posedge wclk) disable iff (!wrstN) sampleStrobe |=> !sampleStrobe)
        else $error("sampleStrobe pulses closer than two wclk cycles");

endmodule

// File: src/streamPkg.sv
/* Stream word layout with sample and marker views, kind codes and field widths */
package streamPkg;

    // Field widths
    localparam int SampleWidth  = 11;
    localparam int ChannelWidth = 3;
    localparam int SeqWidth     = 8;

    // Kind bit in the top position of every word
    localparam logic KindSample = 1'b0;
    localparam logic KindMarker = 1'b1;

    // Sample word
    typedef struct packed {
        logic                   kind;
        logic [SampleWidth-1:0] value;
    } sampleView;

    // Frame marker word
    typedef struct packed {
        logic                    kind;
        logic [ChannelWidth-1:0] channel;
        logic [SeqWidth-1:0]     seq;
    } markerView;

    // One 12-bit word read either way, chosen by the kind bit
    typedef union packed {
        sampleView smp;
        markerView mrk;
    } streamWord;

endpackage

// File: tb.f
src/fifoPkg.sv
src/streamPkg.sv
src/sampleFramer.sv
src/asyncFifo.sv
src/frameUnpacker.sv
src/sampleBridge.sv
verif/sampleBridgeTb.sv

// File: verif/sampleBridgeTb.sv
/* Sample bridge testbench with clocks, reset, stimulus table, LCG samples,
   expected word queue and per-test reporting */
`timescale 1ns/100ps
module sampleBridgeTb;

    localparam int Size     = 8;
    localparam int FrameLen = 4;
    localparam int NumTests = 4;

    // One table row per test
    typedef struct {
        string       name;
        logic [2:0]  channel;
        int          samples;
        bit          readEn;
        logic [15:0] drops;
        int          seqErrs;
    } testEntry;

    logic        rclk = 1'b0;
    logic        wclk = 1'b0;
    logic        asyncReadOK;
    logic        sampleStrobe;
    logic [10:0] sample;
    logic [2:0]  channel;
    logic        readEnable;
    logic [15:0] dropCount;
    logic        sampleValid;
    logic [10:0] sampleOut;
    logic        frameStart;
    logic [2:0]  frameChannel;
    logic [7:0]  frameSeq;
    logic        seqError;

    testEntry             tests [NumTests];
    streamPkg::streamWord expQ [$];
    string                testName = "afterReset";
    int                   errorCount = 0;
    int                   checkCount = 0;
    int                   seqErrCount = 0;
    int                   accepted = 0;
    int                   frameIdx = 0;
    bit                   curReadEn = 1'b0;
    bit                   resetDone = 1'b0;
    logic [7:0]           modelSeq = '0;
    logic [7:0]           lastExpSeq = '0;
    bit                   haveExpSeq = 1'b0;
    logic [31:0]          lcgState = 32'd15;

    // 8 ns read clock, 12 ns write clock
    always #4 rclk = ~rclk;
    always #6 wclk = ~wclk;

    sampleBridge #(.Size(Size), .FrameLen(FrameLen)) u_sampleBridge (
        .rclk(rclk), .wclk(wclk), .asyncReadOK(asyncReadOK), .sampleStrobe(sampleStrobe),
        .sample(sample), .channel(channel), .readEnable(readEnable), .dropCount(dropCount),
        .sampleValid(sampleValid), .sampleOut(sampleOut), .frameStart(frameStart),
        .frameChannel(frameChannel), .frameSeq(frameSeq), .seqError(seqError)
    );

    // ====================
    // Stimulus model
    // ====================
    function automatic logic [10:0] nextSample();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[26:16];
    endfunction

    // With reads held off only the first Size words of a test fit
    task automatic modelWord(input streamPkg::streamWord w);
        if (curReadEn || accepted < Size) begin
            expQ.push_back(w);
            accepted++;
        end
    endtask

    // Marker ahead of the first sample in every frame
    task automatic offerSample(input logic [10:0] value);
        streamPkg::streamWord w;
        if (frameIdx == 0) begin
            w.mrk.kind    = streamPkg::KindMarker;
            w.mrk.channel = channel;
            w.mrk.seq     = modelSeq;
            modelWord(w);
            // Sequence advances even for a lost marker
            modelSeq = modelSeq + 8'd1;
        end
        w.smp.kind  = streamPkg::KindSample;
        w.smp.value = value;
        modelWord(w);
        frameIdx = (frameIdx + 1) % FrameLen;
        @(negedge wclk);
        sampleStrobe = 1'b1;
        sample       = value;
        @(negedge wclk);
        sampleStrobe = 1'b0;
        // Four wclk cycles between strobes
        repeat (2) @(negedge wclk);
    endtask

    task automatic setReadEnable(input bit value);
        @(negedge rclk);
        readEnable = value;
        curReadEn  = value;
    endtask

    // Every expected word has to come out in time
    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (expQ.size() != 0 && cycles < 500) begin
            @(negedge rclk);
            cycles++;
        end
        checkCount++;
        assert (expQ.size() == 0) else begin
            $display("%s timed out with %0d words still missing", testName, expQ.size());
            errorCount++;
        end
    endtask

    // ====================
    // Output scoreboard
    // ====================
    task automatic checkWord();
        streamPkg::streamWord exp;
        streamPkg::streamWord got;
        bit                   expErr;
        checkCount++;
        assert (expQ.size() != 0) else begin
            $display("%s received a word while none was expected", testName);
            errorCount++;
        end
        if (expQ.size() == 0) begin
            return;
        end
        exp = expQ.pop_front();
        expErr = 1'b0;
        if (sampleValid) begin
            got.smp.kind  = streamPkg::KindSample;
            got.smp.value = sampleOut;
        end else begin
            got.mrk.kind    = streamPkg::KindMarker;
            got.mrk.channel = frameChannel;
            got.mrk.seq     = frameSeq;
        end
        if (exp.mrk.kind == streamPkg::KindMarker) begin
            // A marker must follow the previous one by exactly one
            expErr     = haveExpSeq && (exp.mrk.seq != 8'(lastExpSeq + 8'd1));
            haveExpSeq = 1'b1;
            lastExpSeq = exp.mrk.seq;
        end
        assert (got == exp) else begin
            $display("Error: %s expected word %h actual %h", testName, exp, got);
            errorCount++;
        end
        assert (seqError == expErr) else begin
            $display("Error: %s expected seqError %b actual %b", testName, expErr, seqError);
            errorCount++;
        end
    endtask

    // Strobes are single rclk pulses, sampled mid-cycle
    always @(negedge rclk) begin
        if (resetDone) begin
            if (seqError) begin
                seqErrCount++;
            end
            if (sampleValid || frameStart) begin
                checkWord();
            end else begin
                assert (!seqError) else begin
                    $display("%s raised seqError without a marker", testName);
                    errorCount++;
                end
            end
        end
    end

    // ====================
    // Test sequence
    // ====================
    initial begin
        int          errBase;
        logic [15:0] dropBase;
        logic [15:0] dropDelta;
        asyncReadOK  = 1'b0;
        sampleStrobe = 1'b0;
        sample       = '0;
        channel      = '0;
        readEnable   = 1'b0;
        // name, channel, samples, readEnable, drops, seqError pulses
        tests[0] = '{"inOrder",      3'd2, 8,  1'b1, 16'd0, 0};
        tests[1] = '{"backPressure", 3'd2, 12, 1'b0, 16'd7, 0};
        tests[2] = '{"seqGap",       3'd2, 4,  1'b1, 16'd0, 1};
        tests[3] = '{"newChannel",   3'd5, 8,  1'b1, 16'd0, 0};

        repeat (10) @(negedge rclk);
        asyncReadOK = 1'b1;
        // Room for both reset synchronizers and the wok filter
        repeat (10) @(negedge wclk);
        resetDone = 1'b1;
        checkCount++;
        assert (!sampleValid && !frameStart && !seqError && dropCount == 16'd0) else begin
            $display("Error: %s expected 0 0 0 0000 actual %b %b %b %h", testName,
                     sampleValid, frameStart, seqError, dropCount);
            errorCount++;
        end
        $display("test %s: %0d errors", testName, errorCount);

        for (int t = 0; t < NumTests; t++) begin
            testName    = tests[t].name;
            errBase     = errorCount;
            seqErrCount = 0;
            accepted    = 0;
            setReadEnable(tests[t].readEn);
            @(negedge wclk);
            channel  = tests[t].channel;
            dropBase = dropCount;
            for (int i = 0; i < tests[t].samples; i++) begin
                offerSample(nextSample());
            end
            // Last drop lands two wclk edges after its strobe
            repeat (6) @(negedge wclk);
            dropDelta = dropCount - dropBase;
            checkCount++;
            assert (dropDelta == tests[t].drops) else begin
                $display("Error: %s expected drops %0d actual %0d", testName,
                         tests[t].drops, dropDelta);
                errorCount++;
            end
            if (!tests[t].readEn) begin
                setReadEnable(1'b1);
            end
            waitDrain();
            // Any stray word shows up here
            repeat (20) @(negedge rclk);
            checkCount++;
            assert (seqErrCount == tests[t].seqErrs) else begin
                $display("Error: %s expected seqError pulses %0d actual %0d", testName,
                         tests[t].seqErrs, seqErrCount);
                errorCount++;
            end
            $display("test %s: %0d errors", testName, errorCount - errBase);
        end

        $display("tests %0d, checks %0d, errors %0d", NumTests + 1, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
